// ==== serial_pkg.sv ====
// Serial port shared definitions: frame data width and FSM state encodings
package serial_pkg;

  // Data bits per frame
  localparam int DATA_WIDTH = 8;

  // Transmitter states
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    START_BIT = 2'd1,
    DATA      = 2'd2,
    STOP_BIT  = 2'd3
  } tx_state_t;

  // Receiver states
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_t;

endpackage

// ==== tx_fifo.sv ====
// Transmit FIFO, a circular buffer presenting its head entry to the transmitter
module tx_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wr_en,
  input  logic [serial_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                              rd_en,
  output logic [serial_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                              not_empty,
  output logic                              full
);

  import serial_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam logic [AW:0] COUNT_FULL = (AW + 1)'(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [AW:0] count;
  logic push, pop;

  assign push = wr_en && !full;
  assign pop  = rd_en && not_empty;

  assign full      = (count == COUNT_FULL);
  assign not_empty = (count != '0);

  // Head entry straight from storage
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== serial_tx_byte.sv ====
// Byte transmitter sending start bit, eight data bits LSB first and one stop bit
module serial_tx_byte #(
  parameter int CLK_PER_BIT = 434
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              block,
  input  logic                              new_data,
  input  logic [serial_pkg::DATA_WIDTH-1:0] data,
  output logic                              busy,
  output logic                              tx,
  output logic                              load
);

  import serial_pkg::*;

  localparam int CTR_W = $clog2(CLK_PER_BIT);
  localparam int BIT_W = $clog2(DATA_WIDTH);
  localparam logic [CTR_W-1:0] CTR_LAST = CTR_W'(CLK_PER_BIT - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_WIDTH - 1);

  tx_state_t state_d, state_q;
  logic [CTR_W-1:0] ctr_d, ctr_q;
  logic [BIT_W-1:0] bit_d, bit_q;
  logic [DATA_WIDTH-1:0] data_d, data_q;
  logic tx_d, tx_q;
  logic busy_d, busy_q;
  logic block_q;

  assign tx   = tx_q;
  assign busy = busy_q;

  // Capture strobe, the FIFO pops on this
  assign load = (state_q == IDLE) && !block_q && new_data;

  // tx_d holds the line level for the next cycle
  always_comb begin
    state_d = state_q;
    ctr_d   = ctr_q;
    bit_d   = bit_q;
    data_d  = data_q;
    tx_d    = tx_q;
    busy_d  = busy_q;

    case (state_q)
      IDLE: begin
        tx_d   = 1'b1;
        busy_d = block_q;
        ctr_d  = '0;
        bit_d  = '0;
        if (load) begin
          data_d  = data;
          tx_d    = 1'b0;
          busy_d  = 1'b1;
          state_d = START_BIT;
        end
      end

      START_BIT: begin
        ctr_d = ctr_q + 1'b1;
        if (ctr_q == CTR_LAST) begin
          ctr_d   = '0;
          tx_d    = data_q[0];
          state_d = DATA;
        end
      end

      DATA: begin
        ctr_d = ctr_q + 1'b1;
        if (ctr_q == CTR_LAST) begin
          ctr_d = '0;
          if (bit_q == BIT_LAST) begin
            tx_d    = 1'b1;
            state_d = STOP_BIT;
          end else begin
            bit_d = bit_q + 1'b1;
            tx_d  = data_q[bit_d];
          end
        end
      end

      STOP_BIT: begin
        ctr_d = ctr_q + 1'b1;
        if (ctr_q == CTR_LAST) begin
          ctr_d   = '0;
          busy_d  = 1'b0;
          state_d = IDLE;
        end
      end

      default: begin
        tx_d    = 1'b1;
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      ctr_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
      busy_q  <= 1'b0;
      block_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ctr_q   <= ctr_d;
      bit_q   <= bit_d;
      tx_q    <= tx_d;
      busy_q  <= busy_d;
      block_q <= block;
    end
    data_q <= data_d;
  end

endmodule

// ==== serial_rx_byte.sv ====
// Byte receiver with input synchronizer, mid-bit sampling and stop-bit check
module serial_rx_byte #(
  parameter int CLK_PER_BIT = 434
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              rx,
  output logic [serial_pkg::DATA_WIDTH-1:0] data,
  output logic                              new_data,
  output logic                              frame_err
);

  import serial_pkg::*;

  localparam int CTR_W = $clog2(CLK_PER_BIT);
  localparam int BIT_W = $clog2(DATA_WIDTH);
  localparam logic [CTR_W-1:0] CTR_LAST = CTR_W'(CLK_PER_BIT - 1);
  localparam logic [CTR_W-1:0] CTR_HALF = CTR_W'(CLK_PER_BIT / 2 - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_WIDTH - 1);

  rx_state_t state_q;
  logic rx_meta, rx_sync, rx_prev;
  logic [CTR_W-1:0] ctr_q;
  logic [BIT_W-1:0] bit_q;
  logic [DATA_WIDTH-1:0] shift_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic new_data_q, frame_err_q;
  logic sample;

  assign data      = data_q;
  assign new_data  = new_data_q;
  assign frame_err = frame_err_q;

  // One full bit period has elapsed since the last sample point
  assign sample = (ctr_q == CTR_LAST);

  // Two-flop synchronizer, plus one more stage for edge detection
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= RX_IDLE;
      ctr_q       <= '0;
      bit_q       <= '0;
      new_data_q  <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      new_data_q  <= 1'b0;
      frame_err_q <= 1'b0;
      ctr_q       <= ctr_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          ctr_q <= '0;
          bit_q <= '0;
          if (rx_prev && !rx_sync) state_q <= RX_START;
        end
        RX_START: begin
          // Mid start bit, a high line here means a glitch
          if (ctr_q == CTR_HALF) begin
            ctr_q   <= '0;
            state_q <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (sample) begin
            ctr_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == BIT_LAST) state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (sample) begin
            ctr_q       <= '0;
            new_data_q  <= rx_sync;
            frame_err_q <= !rx_sync;
            state_q     <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data path, LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && sample) begin
      shift_q <= {rx_sync, shift_q[DATA_WIDTH-1:1]};
    end
    if (state_q == RX_STOP && sample && rx_sync) begin
      data_q <= shift_q;
    end
  end

endmodule

// ==== serial_port.sv ====
// UART port top level joining the transmit FIFO, transmitter and receiver
module serial_port #(
  parameter int CLK_PER_BIT = 434,
  parameter int FIFO_DEPTH  = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              block,
  input  logic                              wr_en,
  input  logic [serial_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                              rx,
  output logic                              full,
  output logic                              busy,
  output logic                              tx,
  output logic [serial_pkg::DATA_WIDTH-1:0] rx_data,
  output logic                              rx_valid,
  output logic                              rx_frame_err
);

  import serial_pkg::*;

  logic [DATA_WIDTH-1:0] fifo_rd_data;
  logic fifo_not_empty;
  logic tx_load;

  // Transmit path, FIFO pops on the transmitter's capture pulse
  tx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (tx_load),
    .rd_data  (fifo_rd_data),
    .not_empty(fifo_not_empty),
    .full     (full)
  );

  serial_tx_byte #(
    .CLK_PER_BIT(CLK_PER_BIT)
  ) u_tx (
    .clk     (clk),
    .rst     (rst),
    .block   (block),
    .new_data(fifo_not_empty),
    .data    (fifo_rd_data),
    .busy    (busy),
    .tx      (tx),
    .load    (tx_load)
  );

  // Receive path
  serial_rx_byte #(
    .CLK_PER_BIT(CLK_PER_BIT)
  ) u_rx (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .data     (rx_data),
    .new_data (rx_valid),
    .frame_err(rx_frame_err)
  );

endmodule

// ==== serial_port_assert.sv ====
// Concurrent protocol checks on the serial port FIFO, transmitter and receiver
module serial_port_assert #(
  parameter int FIFO_DEPTH = 8
) (
  input logic                          clk,
  input logic                          rst,
  input logic                          tx,
  input serial_pkg::tx_state_t         tx_state,
  input logic                          load,
  input logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr,
  input logic                          full,
  input logic                          wr_en,
  input logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr,
  input logic                          rx_valid,
  input logic                          rx_frame_err
);

  timeunit 1ns;
  timeprecision 100ps;

  import serial_pkg::*;

  // Number of assertion failures
  int fail_count = 0;

  // Line idles high
  idle_tx_high: assert property (@(posedge clk) disable iff (rst) tx_state == IDLE |-> tx)
    else begin
      $error("tx low while the transmitter is idle");
      fail_count++;
    end

  // Capture only while the pointers show a waiting byte
  load_needs_data: assert property (@(posedge clk) disable iff (rst)
    load |-> (wr_ptr != rd_ptr) || full)
    else begin
      $error("load pulse while the FIFO is empty");
      fail_count++;
    end

  // Write pointer must hold when a write hits a full FIFO
  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    full && wr_en |=> $stable(wr_ptr))
    else begin
      $error("write accepted while the FIFO is full");
      fail_count++;
    end

  rx_pulses_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(rx_valid && rx_frame_err))
    else begin
      $error("rx_valid and rx_frame_err high together");
      fail_count++;
    end

endmodule

bind serial_port serial_port_assert #(
  .FIFO_DEPTH(FIFO_DEPTH)
) u_chk (
  .clk         (clk),
  .rst         (rst),
  .tx          (tx),
  .tx_state    (u_tx.state_q),
  .load        (tx_load),
  .rd_ptr      (u_fifo.rd_ptr),
  .full        (full),
  .wr_en       (wr_en),
  .wr_ptr      (u_fifo.wr_ptr),
  .rx_valid    (rx_valid),
  .rx_frame_err(rx_frame_err)
);

// ==== tb_serial_port.sv ====
// Testbench for the serial port with loopback and bit-banged receive traffic
module tb_serial_port;

  timeunit 1ns;
  timeprecision 100ps;

  import serial_pkg::*;

  localparam int CPB   = 8;
  localparam int DEPTH = 8;
  localparam int LIMIT = 300 * CPB;

  logic clk;
  logic rst;
  logic block;
  logic wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic full;
  logic busy;
  logic tx;
  logic [DATA_WIDTH-1:0] rx_data;
  logic rx_valid;
  logic rx_frame_err;
  logic rx_line;
  logic loop_sel;
  logic bang_line;

  // Expected bytes in write order with exp_rd as the scoreboard's read index
  logic [DATA_WIDTH-1:0] exp_q[$];
  int exp_rd = 0;
  int rx_count = 0;
  int ferr_count = 0;
  int sb_errors = 0;
  int errors = 0;
  int tests = 0;
  int failed = 0;
  int err_start;
  int rx_start;
  int ferr_start;

  // DUT rx sees either its own tx or the bit-banged line
  assign rx_line = loop_sel ? tx : bang_line;

  serial_port #(
    .CLK_PER_BIT(CPB),
    .FIFO_DEPTH (DEPTH)
  ) DUT (
    .rx(rx_line),
    .*
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Scoreboard on received bytes and framing errors
  always @(posedge clk) begin
    if (!rst && rx_valid) begin
      rx_count++;
      if (exp_rd >= exp_q.size()) begin
        $display("Byte %h received although none was expected", rx_data);
        sb_errors++;
      end else begin
        if (rx_data !== exp_q[exp_rd]) begin
          $display("ERR rx_data: got %h, expected %h", rx_data, exp_q[exp_rd]);
          sb_errors++;
        end
        exp_rd++;
      end
    end
    if (!rst && rx_frame_err) begin
      ferr_count++;
    end
  end

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_busy(logic level);
    int t;
    t = 0;
    while (busy !== level && t < LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (busy !== level) begin
      $display("Timed out waiting for busy to become %0b", level);
      errors++;
    end
  endtask

  // Wait until every expected byte has been received
  task automatic drain();
    int t;
    t = 0;
    while (exp_rd < exp_q.size() && t < LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (exp_rd < exp_q.size()) begin
      $display("Timed out with %0d bytes never received", exp_q.size() - exp_rd);
      errors++;
    end
  endtask

  task automatic push_byte(logic [DATA_WIDTH-1:0] b, logic queued);
    int t;
    t = 0;
    while (queued && full && t < LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (queued && full) begin
      $display("FIFO stayed full, byte %h could not be written", b);
      errors++;
    end
    if (queued) begin
      exp_q.push_back(b);
    end
    wr_en   = 1'b1;
    wr_data = b;
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  // Start bit, data LSB first, then the given stop level
  task automatic bang_frame(logic [DATA_WIDTH-1:0] b, logic stop);
    logic [DATA_WIDTH+1:0] f;
    f = {stop, b, 1'b0};
    repeat (DATA_WIDTH + 2) begin
      bang_line = f[0];
      f = f >> 1;
      wait_cycles(CPB);
    end
    bang_line = 1'b1;
    wait_cycles(2 * CPB);
  endtask

  task automatic start_test();
    err_start  = errors + sb_errors;
    rx_start   = rx_count;
    ferr_start = ferr_count;
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors + sb_errors == err_start) begin
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors + sb_errors - err_start);
    end
  endtask

  initial begin
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH+1:0] frame;
    int k;
    void'($urandom(32'h7963));
    rst       = 1'b1;
    block     = 1'b0;
    wr_en     = 1'b0;
    wr_data   = '0;
    loop_sel  = 1'b1;
    bang_line = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    start_test();
    check("tx", 32'(tx), 32'd1);
    check("busy", 32'(busy), 32'd0);
    check("full", 32'(full), 32'd0);
    check("rx_valid", 32'(rx_valid), 32'd0);
    check("rx_frame_err", 32'(rx_frame_err), 32'd0);
    wait_cycles(20 * CPB);
    check("rx_count", 32'(rx_count), 32'd0);
    end_test("reset state");

    start_test();
    repeat (20) begin
      push_byte(DATA_WIDTH'($urandom), 1'b1);
      wait_cycles($urandom_range(0, 3 * CPB));
    end
    drain();
    check("rx_count", 32'(rx_count - rx_start), 32'd20);
    end_test("loopback order");

    start_test();
    wait_busy(1'b0);
    b = DATA_WIDTH'($urandom);
    push_byte(b, 1'b1);
    wait_busy(1'b1);
    // Line levels of the whole frame from the start bit on
    frame = {1'b1, b, 1'b0};
    k = 0;
    while (busy && k < 20 * CPB) begin
      if (k % CPB == CPB / 2) begin
        check("tx", 32'(tx), 32'(frame[0]));
        frame = frame >> 1;
      end
      k++;
      @(negedge clk);
    end
    check("busy cycles", 32'(k), 32'(10 * CPB));
    drain();
    end_test("frame shape");

    start_test();
    wait_busy(1'b0);
    block = 1'b1;
    wait_cycles(2);
    repeat (3) begin
      push_byte(DATA_WIDTH'($urandom), 1'b1);
    end
    k = 0;
    repeat (12 * CPB) begin
      if (!tx || !busy) begin
        k++;
      end
      @(negedge clk);
    end
    if (k != 0) begin
      $display("Line left idle or busy dropped in %0d cycles while blocked", k);
      errors++;
    end
    block = 1'b0;
    drain();
    end_test("block");

    start_test();
    wait_busy(1'b0);
    block = 1'b1;
    wait_cycles(2);
    repeat (DEPTH) begin
      push_byte(DATA_WIDTH'($urandom), 1'b1);
    end
    check("full", 32'(full), 32'd1);
    push_byte(DATA_WIDTH'($urandom), 1'b0);
    check("full", 32'(full), 32'd1);
    block = 1'b0;
    drain();
    wait_cycles(15 * CPB);
    check("rx_count", 32'(rx_count - rx_start), 32'(DEPTH));
    end_test("full");

    start_test();
    wait_busy(1'b0);
    loop_sel = 1'b0;
    bang_frame(8'hA5, 1'b0);
    k = 0;
    while (ferr_count == ferr_start && k < LIMIT) begin
      @(negedge clk);
      k++;
    end
    if (ferr_count == ferr_start) begin
      $display("Timed out waiting for a framing error pulse");
    end
    check("rx_frame_err pulses", 32'(ferr_count - ferr_start), 32'd1);
    check("rx_valid pulses", 32'(rx_count - rx_start), 32'd0);
    exp_q.push_back(8'h3C);
    bang_frame(8'h3C, 1'b1);
    drain();
    check("rx_frame_err pulses", 32'(ferr_count - ferr_start), 32'd1);
    end_test("framing error");

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests, failed, errors + sb_errors, DUT.u_chk.fail_count);
    if (errors + sb_errors == 0 && DUT.u_chk.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== serial_port.f ====
serial_pkg.sv
tx_fifo.sv
serial_tx_byte.sv
serial_rx_byte.sv
serial_port.sv
serial_port_assert.sv
tb_serial_port.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the serial port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_serial_port -f serial_port.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_serial_port +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
